//--- src/busMaster_params.svh
`ifndef BUS_MASTER_PARAMS_SVH
`define BUS_MASTER_PARAMS_SVH

// local word memory
`define BM_MEM_DEPTH          4096
`define BM_ADDR_WIDTH         12
`define BM_DATA_WIDTH         16

// slave addressing and frame layout
`define BM_SLAVE_ID_WIDTH     2
`define BM_START_PATTERN_LEN  3
// start pattern, slave id, rd/wr bit, burst bit, address
`define BM_CONTROL_LEN        (`BM_START_PATTERN_LEN + `BM_SLAVE_ID_WIDTH + 2 + `BM_ADDR_WIDTH)
// start pattern followed by slave id
`define BM_ARB_REQ_LEN        (`BM_START_PATTERN_LEN + `BM_SLAVE_ID_WIDTH)
`define BM_GRANT_RUN          2

`endif

//--- src/busMasterPkg.sv
`default_nettype none

`include "busMaster_params.svh"

package busMasterPkg;

    typedef logic [`BM_ADDR_WIDTH-1:0]     memAddrT;
    typedef logic [`BM_DATA_WIDTH-1:0]     dataWordT;
    typedef logic [`BM_SLAVE_ID_WIDTH-1:0] slaveIdT;

    // control frame, first field goes out first
    typedef struct packed {
        logic [`BM_START_PATTERN_LEN-1:0] startPattern;
        slaveIdT                          slaveId;
        logic                             rdWr;
        logic                             burst;
        memAddrT                          address;
    } controlFieldsT;

    // built by field, shifted out as one raw word
    typedef union packed {
        controlFieldsT              fields;
        logic [`BM_CONTROL_LEN-1:0] raw;
    } controlFrameU;

    typedef enum logic [2:0] {
        idle,
        arbitrate,
        sendControl,
        transfer,
        finish
    } masterPhaseE;

endpackage

`default_nettype wire

//--- src/localMemory.sv
`default_nettype none

`include "busMaster_params.svh"

module localMemory
    import busMasterPkg::*;
(
    input  wire logic     clk,
    input  wire logic     busy,
    input  wire logic     loadEn,
    input  wire memAddrT  loadAddr,
    input  wire dataWordT loadData,
    input  wire logic     capWe,
    input  wire memAddrT  capAddr,
    input  wire dataWordT capData,
    input  wire memAddrT  memRdAddr,
    input  wire memAddrT  rdAddr,
    output dataWordT      memRdData,
    output dataWordT      dataOut
);

    dataWordT mem [`BM_MEM_DEPTH];

    logic     wrEn;
    memAddrT  wrAddr;
    dataWordT wrData;
    memAddrT  rdSel;

    // transfer side owns the array while a command runs
    assign wrEn   = busy ? capWe   : loadEn;
    assign wrAddr = busy ? capAddr : loadAddr;
    assign wrData = busy ? capData : loadData;
    assign rdSel  = busy ? memRdAddr : rdAddr;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        // external readback holds its last word during a command
        if (busy) begin
            memRdData <= mem[rdSel];
        end else begin
            dataOut <= mem[rdSel];
        end
    end

    // user load port must stay quiet until doneCom
    loadWhileIdle: assert property (@(posedge clk) !(busy && loadEn));

endmodule

`default_nettype wire

//--- src/arbiterLink.sv
`default_nettype none

`include "busMaster_params.svh"

module arbiterLink
    import busMasterPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    arbReq,
    input  wire slaveIdT reqSlaveId,
    input  wire logic    arbCont,
    input  wire logic    releaseBus,
    output logic         arbSend,
    output logic         granted
);

    localparam int reqCntW = $clog2(`BM_ARB_REQ_LEN + 1);
    localparam int runCntW = $clog2(`BM_GRANT_RUN + 1);
    localparam logic [runCntW-1:0] runLast = runCntW'(`BM_GRANT_RUN - 1);

    logic [`BM_ARB_REQ_LEN-1:0] reqShift;
    logic [reqCntW-1:0]         reqLeft;
    logic [runCntW-1:0]         highRun;
    logic                       waiting;
    logic                       holding;

    // request bits first, then the bus hold level
    assign arbSend = (reqLeft != '0) ? reqShift[`BM_ARB_REQ_LEN-1] : holding;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqShift <= '0;
            reqLeft  <= '0;
            highRun  <= '0;
            waiting  <= 1'b0;
            holding  <= 1'b0;
            granted  <= 1'b0;
        end else begin
            granted <= 1'b0;
            if (arbReq) begin
                reqShift <= {{`BM_START_PATTERN_LEN{1'b1}}, reqSlaveId};
                reqLeft  <= reqCntW'(`BM_ARB_REQ_LEN);
            end else if (reqLeft != '0) begin
                reqShift <= reqShift << 1;
                reqLeft  <= reqLeft - 1'b1;
                if (reqLeft == reqCntW'(1)) begin
                    waiting <= 1'b1;
                    highRun <= '0;
                end
            end else if (waiting) begin
                // grant is a run of consecutive high samples
                if (!arbCont) begin
                    highRun <= '0;
                end else if (highRun == runLast) begin
                    waiting <= 1'b0;
                    holding <= 1'b1;
                    granted <= 1'b1;
                end else begin
                    highRun <= highRun + 1'b1;
                end
            end
            if (releaseBus) begin
                holding <= 1'b0;
            end
        end
    end

    grantAfterRequest: assert property (@(posedge clk) disable iff (!rstN)
        granted |-> $past(arbCont) && $past(arbCont, 2) && $past(reqLeft == '0, 2));

endmodule

`default_nettype wire

//--- src/controlSerializer.sv
`default_nettype none

`include "busMaster_params.svh"

module controlSerializer
    import busMasterPkg::*;
(
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         frameLoad,
    input  wire controlFrameU frame,
    output logic              control,
    output logic              frameDone
);

    localparam int bitCntW = $clog2(`BM_CONTROL_LEN);
    localparam logic [bitCntW-1:0] finalBit = bitCntW'(`BM_CONTROL_LEN - 1);

    logic [`BM_CONTROL_LEN-1:0] shiftReg;
    logic [bitCntW-1:0]         bitCnt;
    logic                       shifting;

    // line idles low between frames
    assign control = shifting && shiftReg[`BM_CONTROL_LEN-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg  <= '0;
            bitCnt    <= '0;
            shifting  <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            if (frameLoad) begin
                shiftReg <= frame.raw;
                bitCnt   <= '0;
                shifting <= 1'b1;
            end else if (shifting) begin
                shiftReg <= shiftReg << 1;
                bitCnt   <= bitCnt + 1'b1;
                if (bitCnt == finalBit) begin
                    shifting  <= 1'b0;
                    frameDone <= 1'b1;
                end
            end
        end
    end

    noReloadMidFrame: assert property (@(posedge clk) disable iff (!rstN)
        frameLoad |-> !shifting);

endmodule

`default_nettype wire

//--- src/dataLink.sv
`default_nettype none

`include "busMaster_params.svh"

module dataLink
    import busMasterPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     wordGo,
    input  wire logic     wordRead,
    input  wire memAddrT  wordAddr,
    input  wire logic     wordLast,
    input  wire dataWordT memRdData,
    input  wire logic     rD,
    input  wire logic     ready,
    output memAddrT       memRdAddr,
    output logic          capWe,
    output memAddrT       capAddr,
    output dataWordT      capData,
    output logic          valid,
    output logic          wrD,
    output logic          last,
    output logic          wordDone
);

    localparam int bitCntW = $clog2(`BM_DATA_WIDTH);
    localparam logic [bitCntW-1:0] finalBit = bitCntW'(`BM_DATA_WIDTH - 1);

    logic               fetchPend;
    logic               readMode;
    logic               lastWord;
    logic [bitCntW-1:0] bitCnt;
    dataWordT           shiftReg;
    logic               bitMove;

    ////////////////////////////////////////////////////////////////////////////
    // pin side
    ////////////////////////////////////////////////////////////////////////////

    // a bit moves only when the slave is ready
    assign bitMove = valid && ready;

    // word address is held by the sequencer for the whole word
    assign memRdAddr = wordAddr;
    assign capAddr   = wordAddr;
    assign capData   = shiftReg;

    assign wrD  = valid && !readMode && shiftReg[`BM_DATA_WIDTH-1];
    assign last = valid && lastWord;

    ////////////////////////////////////////////////////////////////////////////
    // word sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPend <= 1'b0;
            readMode  <= 1'b0;
            lastWord  <= 1'b0;
            bitCnt    <= '0;
            valid     <= 1'b0;
            capWe     <= 1'b0;
            wordDone  <= 1'b0;
        end else begin
            capWe    <= 1'b0;
            wordDone <= 1'b0;
            if (wordGo) begin
                fetchPend <= 1'b1;
                readMode  <= wordRead;
                lastWord  <= wordLast;
            end else if (fetchPend) begin
                // memory word is on memRdData now
                fetchPend <= 1'b0;
                valid     <= 1'b1;
                bitCnt    <= '0;
            end else if (bitMove) begin
                bitCnt <= bitCnt + 1'b1;
                if (bitCnt == finalBit) begin
                    valid    <= 1'b0;
                    wordDone <= 1'b1;
                    capWe    <= readMode;
                end
            end
        end
    end

    // MSB first both ways, rD shifts in at the bottom
    always_ff @(posedge clk) begin
        if (fetchPend) begin
            shiftReg <= memRdData;
        end else if (bitMove) begin
            shiftReg <= {shiftReg[`BM_DATA_WIDTH-2:0], readMode ? rD : 1'b0};
        end
    end

    validUntilDone: assert property (@(posedge clk) disable iff (!rstN)
        valid |-> !wordGo && $stable(wordAddr));

endmodule

`default_nettype wire

//--- src/masterControl.sv
`default_nettype none

module masterControl
    import busMasterPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    start,
    input  wire logic    rdWr,
    input  wire slaveIdT slaveId,
    input  wire memAddrT address,
    input  wire memAddrT lastAddress,
    input  wire logic    granted,
    input  wire logic    frameDone,
    input  wire logic    wordDone,
    output logic         busy,
    output logic         arbReq,
    output slaveIdT      reqSlaveId,
    output logic         frameLoad,
    output controlFrameU frame,
    output logic         wordGo,
    output logic         wordRead,
    output memAddrT      wordAddr,
    output logic         wordLast,
    output logic         releaseBus,
    output logic         doneCom
);

    masterPhaseE phase;
    memAddrT     wordsLeft;

    assign busy       = (phase != idle);
    assign reqSlaveId = frame.fields.slaveId;
    // rdWr high means write
    assign wordRead   = !frame.fields.rdWr;
    assign wordLast   = (wordsLeft == '0);

    ////////////////////////////////////////////////////////////////////////////
    // phase sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase      <= idle;
            frame      <= '0;
            wordAddr   <= '0;
            wordsLeft  <= '0;
            arbReq     <= 1'b0;
            frameLoad  <= 1'b0;
            wordGo     <= 1'b0;
            releaseBus <= 1'b0;
            doneCom    <= 1'b0;
        end else begin
            arbReq     <= 1'b0;
            frameLoad  <= 1'b0;
            wordGo     <= 1'b0;
            releaseBus <= 1'b0;
            doneCom    <= 1'b0;
            unique case (phase)
                idle: begin
                    if (start) begin
                        frame.fields.startPattern <= '1;
                        frame.fields.slaveId      <= slaveId;
                        frame.fields.rdWr         <= rdWr;
                        frame.fields.burst        <= (lastAddress != address);
                        frame.fields.address      <= address;
                        wordAddr  <= address;
                        wordsLeft <= lastAddress - address;
                        arbReq    <= 1'b1;
                        phase     <= arbitrate;
                    end
                end
                arbitrate: begin
                    if (granted) begin
                        frameLoad <= 1'b1;
                        phase     <= sendControl;
                    end
                end
                sendControl: begin
                    if (frameDone) begin
                        wordGo <= 1'b1;
                        phase  <= transfer;
                    end
                end
                transfer: begin
                    // one word per wordDone, address steps up
                    if (wordDone) begin
                        if (wordLast) begin
                            releaseBus <= 1'b1;
                            phase      <= finish;
                        end else begin
                            wordAddr  <= wordAddr + 1'b1;
                            wordsLeft <= wordsLeft - 1'b1;
                            wordGo    <= 1'b1;
                        end
                    end
                end
                finish: begin
                    doneCom <= 1'b1;
                    phase   <= idle;
                end
                default: phase <= idle;
            endcase
        end
    end

    noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        busy |-> !start);

endmodule

`default_nettype wire

//--- src/busMaster.sv
`default_nettype none

module busMaster
    import busMasterPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     start,
    input  wire logic     rdWr,
    input  wire slaveIdT  slaveId,
    input  wire memAddrT  address,
    input  wire memAddrT  lastAddress,
    input  wire logic     loadEn,
    input  wire memAddrT  loadAddr,
    input  wire dataWordT loadData,
    input  wire memAddrT  rdAddr,
    input  wire logic     rD,
    input  wire logic     ready,
    input  wire logic     arbCont,
    output logic          doneCom,
    output dataWordT      dataOut,
    output logic          control,
    output logic          wrD,
    output logic          valid,
    output logic          last,
    output logic          arbSend
);

    ////////////////////////////////////////////////////////////////////////////
    // internal strobes
    ////////////////////////////////////////////////////////////////////////////

    logic         busy;
    logic         arbReq;
    slaveIdT      reqSlaveId;
    logic         granted;
    logic         frameLoad;
    controlFrameU frame;
    logic         frameDone;
    logic         wordGo;
    logic         wordRead;
    memAddrT      wordAddr;
    logic         wordLast;
    logic         wordDone;
    logic         releaseBus;
    memAddrT      memRdAddr;
    dataWordT     memRdData;
    logic         capWe;
    memAddrT      capAddr;
    dataWordT     capData;

    masterControl masterControl_i (
        .clk(clk), .rstN(rstN), .start(start), .rdWr(rdWr), .slaveId(slaveId),
        .address(address), .lastAddress(lastAddress), .granted(granted),
        .frameDone(frameDone), .wordDone(wordDone), .busy(busy), .arbReq(arbReq),
        .reqSlaveId(reqSlaveId), .frameLoad(frameLoad), .frame(frame),
        .wordGo(wordGo), .wordRead(wordRead), .wordAddr(wordAddr),
        .wordLast(wordLast), .releaseBus(releaseBus), .doneCom(doneCom)
    );

    arbiterLink arbiterLink_i (
        .clk(clk), .rstN(rstN), .arbReq(arbReq), .reqSlaveId(reqSlaveId),
        .arbCont(arbCont), .releaseBus(releaseBus), .arbSend(arbSend),
        .granted(granted)
    );

    controlSerializer controlSerializer_i (
        .clk(clk), .rstN(rstN), .frameLoad(frameLoad), .frame(frame),
        .control(control), .frameDone(frameDone)
    );

    dataLink dataLink_i (
        .clk(clk), .rstN(rstN), .wordGo(wordGo), .wordRead(wordRead),
        .wordAddr(wordAddr), .wordLast(wordLast), .memRdData(memRdData),
        .rD(rD), .ready(ready), .memRdAddr(memRdAddr), .capWe(capWe),
        .capAddr(capAddr), .capData(capData), .valid(valid), .wrD(wrD),
        .last(last), .wordDone(wordDone)
    );

    localMemory localMemory_i (
        .clk(clk), .busy(busy), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .capWe(capWe), .capAddr(capAddr), .capData(capData),
        .memRdAddr(memRdAddr), .rdAddr(rdAddr), .memRdData(memRdData),
        .dataOut(dataOut)
    );

endmodule

`default_nettype wire

//--- tb/tbClock.sv
`default_nettype none

module tbClock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/busMasterChecker.sv
`default_nettype none

`include "busMaster_params.svh"

module busMasterChecker
    import busMasterPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     start,
    input  wire logic     rdWr,
    input  wire slaveIdT  slaveId,
    input  wire memAddrT  address,
    input  wire memAddrT  lastAddress,
    input  wire logic     loadEn,
    input  wire memAddrT  loadAddr,
    input  wire dataWordT loadData,
    input  wire memAddrT  rdAddr,
    input  wire logic     rdCheck,
    input  wire logic     ready,
    input  wire logic     doneCom,
    input  wire dataWordT dataOut,
    input  wire logic     control,
    input  wire logic     wrD,
    input  wire logic     valid,
    input  wire logic     last,
    input  wire logic     arbSend,
    input  wire memAddrT  slaveAddr,
    output dataWordT      slaveWord,
    output int            mismatchCount,
    output int            otherCount,
    output int            doneCount
);

    localparam int bitW = $clog2(`BM_DATA_WIDTH);
    localparam logic [bitW-1:0] msbIdx = bitW'(`BM_DATA_WIDTH - 1);

    dataWordT                   modelMem [`BM_MEM_DEPTH];
    logic                       cmdActive;
    logic                       cmdWrite;
    slaveIdT                    cmdSlave;
    memAddrT                    cmdFirst;
    memAddrT                    cmdLast;
    memAddrT                    curAddr;
    logic [`BM_ARB_REQ_LEN-1:0] reqBits;
    logic [`BM_CONTROL_LEN-1:0] frameBits;
    int                         reqCnt;
    int                         frameCnt;
    int                         wordCnt;
    logic [bitW-1:0]            bitCnt;
    logic                       resetChecked;
    logic                       rbPend;
    memAddrT                    rbAddr;

    // word the slave returns for each address, every address bit matters
    function automatic dataWordT slaveRef(input memAddrT a);
        return (dataWordT'(a) * 16'h9E37) ^ 16'h5AC3;
    endfunction

    assign slaveWord = slaveRef(slaveAddr);

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        mismatchCount++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic expectLow(input string name, input logic value);
        if (value !== 1'b0) begin
            reportMismatch(name, 32'(value), 32'd0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampled on the falling edge, all pins settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [`BM_ARB_REQ_LEN-1:0] expReq;
        logic [`BM_CONTROL_LEN-1:0] expFrame;
        dataWordT                   expWord;
        logic                       expLast;
        if (!rstN) begin
            mismatchCount = 0;
            otherCount    = 0;
            doneCount     = 0;
            cmdActive     = 1'b0;
            resetChecked  = 1'b0;
            rbPend        = 1'b0;
        end else begin
            if (!resetChecked) begin
                expectLow("control", control);
                expectLow("wrD", wrD);
                expectLow("valid", valid);
                expectLow("last", last);
                expectLow("arbSend", arbSend);
                expectLow("doneCom", doneCom);
                resetChecked = 1'b1;
            end
            // dataOut follows rdAddr by one cycle
            if (rbPend && dataOut !== modelMem[rbAddr]) begin
                reportMismatch("dataOut", 32'(dataOut), 32'(modelMem[rbAddr]));
            end
            rbPend = rdCheck;
            rbAddr = rdAddr;
            if (loadEn) begin
                modelMem[loadAddr] = loadData;
            end
            if (start) begin
                cmdActive = 1'b1;
                cmdWrite  = rdWr;
                cmdSlave  = slaveId;
                cmdFirst  = address;
                cmdLast   = lastAddress;
                curAddr   = address;
                reqCnt    = 0;
                frameCnt  = 0;
                wordCnt   = 0;
                bitCnt    = '0;
            end else if (cmdActive) begin
                // request is start pattern then slave id
                if ((reqCnt > 0 || arbSend) && reqCnt < `BM_ARB_REQ_LEN) begin
                    reqBits = {reqBits[`BM_ARB_REQ_LEN-2:0], arbSend};
                    reqCnt++;
                    expReq = {{`BM_START_PATTERN_LEN{1'b1}}, cmdSlave};
                    if (reqCnt == `BM_ARB_REQ_LEN && reqBits !== expReq) begin
                        reportMismatch("arbSend request", 32'(reqBits), 32'(expReq));
                    end
                end
                if ((frameCnt > 0 || control) && frameCnt < `BM_CONTROL_LEN) begin
                    frameBits = {frameBits[`BM_CONTROL_LEN-2:0], control};
                    frameCnt++;
                    expFrame = {{`BM_START_PATTERN_LEN{1'b1}}, cmdSlave, cmdWrite,
                                cmdLast != cmdFirst, cmdFirst};
                    if (frameCnt == `BM_CONTROL_LEN && frameBits !== expFrame) begin
                        reportMismatch("control frame", 32'(frameBits), 32'(expFrame));
                    end
                end
                expWord = modelMem[curAddr];
                expLast = valid && (curAddr == cmdLast);
                if (last !== expLast) begin
                    reportMismatch("last", 32'(last), 32'(expLast));
                end
                // write bit must hold through ready gaps
                if (valid && cmdWrite && wrD !== expWord[msbIdx - bitCnt]) begin
                    reportMismatch("wrD", 32'(wrD), 32'(expWord[msbIdx - bitCnt]));
                end
                if (valid && ready) begin
                    bitCnt = bitCnt + 1'b1;
                    if (bitCnt == '0) begin
                        if (!cmdWrite) begin
                            modelMem[curAddr] = slaveRef(curAddr);
                        end
                        curAddr = curAddr + 1'b1;
                        wordCnt++;
                    end
                end
                if (doneCom) begin
                    doneCount++;
                    cmdActive = 1'b0;
                    expectLow("arbSend", arbSend);
                    if (wordCnt != int'(cmdLast - cmdFirst) + 1) begin
                        otherCount++;
                        $display("doneCom at %0t came after %0d words, %0d were commanded",
                                 $time, wordCnt, int'(cmdLast - cmdFirst) + 1);
                    end
                end
            end else if (doneCom) begin
                otherCount++;
                $display("doneCom pulsed at %0t with no command in flight", $time);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/busMasterTb.sv
`default_nettype none

`include "busMaster_params.svh"

module busMasterTb
    import busMasterPkg::*;
();

    localparam int drive = 10;
    localparam int numCmds = 3;
    localparam int totalWords = 1 + 8 + 10;
    localparam int loadWords = 64;
    localparam int readWords = 64;
    // worst case ready stretches each bit about eightfold
    localparam longint limitCycles = totalWords * `BM_DATA_WIDTH * 8 + numCmds * 80
                                     + loadWords + readWords + 100;
    localparam longint timeLimit = limitCycles * 100;
    localparam int bitW = $clog2(`BM_DATA_WIDTH);
    localparam logic [bitW-1:0] msbIdx = bitW'(`BM_DATA_WIDTH - 1);

    logic            clk;
    logic            rstN;
    logic            start;
    logic            rdWr;
    slaveIdT         slaveId;
    memAddrT         address;
    memAddrT         lastAddress;
    logic            loadEn;
    memAddrT         loadAddr;
    dataWordT        loadData;
    memAddrT         rdAddr;
    logic            rdCheck;
    logic            rD;
    logic            ready;
    logic            arbCont;
    logic            doneCom;
    dataWordT        dataOut;
    logic            control;
    logic            wrD;
    logic            valid;
    logic            last;
    logic            arbSend;
    memAddrT         cmdAddr;
    memAddrT         wordIdx;
    logic [bitW-1:0] bitIdx;
    memAddrT         slaveAddr;
    dataWordT        slaveWord;
    logic [31:0]     loadSeed;
    int              mismatchCount;
    int              otherCount;
    int              doneCount;
    int              tbErrors;

    tbClock #(.period(100)) tbClock_i (.clk(clk));

    busMaster busMaster_i (
        .clk(clk), .rstN(rstN), .start(start), .rdWr(rdWr), .slaveId(slaveId),
        .address(address), .lastAddress(lastAddress), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .rdAddr(rdAddr), .rD(rD),
        .ready(ready), .arbCont(arbCont), .doneCom(doneCom), .dataOut(dataOut),
        .control(control), .wrD(wrD), .valid(valid), .last(last), .arbSend(arbSend)
    );

    busMasterChecker busMasterChecker_i (
        .clk(clk), .rstN(rstN), .start(start), .rdWr(rdWr), .slaveId(slaveId),
        .address(address), .lastAddress(lastAddress), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .rdAddr(rdAddr), .rdCheck(rdCheck),
        .ready(ready), .doneCom(doneCom), .dataOut(dataOut), .control(control),
        .wrD(wrD), .valid(valid), .last(last), .arbSend(arbSend),
        .slaveAddr(slaveAddr), .slaveWord(slaveWord), .mismatchCount(mismatchCount),
        .otherCount(otherCount), .doneCount(doneCount)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // slave and arbiter models
    ////////////////////////////////////////////////////////////////////////////

    // slave returns the reference word, MSB first
    assign slaveAddr = cmdAddr + wordIdx;
    assign rD        = slaveWord[msbIdx - bitIdx];

    initial begin : slaveModel
        logic [31:0] seed;
        logic        moved;
        seed    = 32'd23;
        moved   = 1'b0;
        bitIdx  = '0;
        wordIdx = '0;
        ready   = 1'b0;
        forever begin
            @(posedge clk);
            #drive;
            if (moved) begin
                bitIdx = bitIdx + 1'b1;
                if (bitIdx == '0) begin
                    wordIdx = wordIdx + 1'b1;
                end
            end
            if (doneCom) begin
                bitIdx  = '0;
                wordIdx = '0;
            end
            seed  = lcgNext(seed);
            // ready roughly three cycles in four
            ready = (seed[17:16] != 2'b00);
            moved = valid && ready;
        end
    end

    initial begin : arbiterModel
        logic [31:0] seed;
        int          step;
        int          hold;
        seed    = 32'd23;
        step    = 0;
        hold    = 0;
        arbCont = 1'b0;
        forever begin
            @(posedge clk);
            #drive;
            case (step)
                0: begin
                    // first request bit is always high
                    if (arbSend) begin
                        step = 1;
                        hold = `BM_ARB_REQ_LEN - 1;
                    end
                end
                1: begin
                    if (hold == 0) begin
                        seed = lcgNext(seed);
                        hold = int'(seed[18:16]);
                        step = 2;
                    end else begin
                        hold--;
                    end
                end
                2: begin
                    if (hold == 0) begin
                        arbCont = 1'b1;
                        step    = 3;
                    end else begin
                        hold--;
                    end
                end
                default: begin
                    if (doneCom) begin
                        arbCont = 1'b0;
                        step    = 0;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadRange(input memAddrT first, input memAddrT lastA);
        for (int a = int'(first); a <= int'(lastA); a++) begin
            @(posedge clk);
            #drive;
            loadSeed = lcgNext(loadSeed);
            loadEn   = 1'b1;
            loadAddr = memAddrT'(a);
            loadData = loadSeed[31:16];
        end
        @(posedge clk);
        #drive;
        loadEn = 1'b0;
    endtask

    task automatic runCommand(input logic write, input slaveIdT sid, input memAddrT first,
                              input memAddrT lastA);
        @(posedge clk);
        #drive;
        cmdAddr     = first;
        start       = 1'b1;
        rdWr        = write;
        slaveId     = sid;
        address     = first;
        lastAddress = lastA;
        @(posedge clk);
        #drive;
        start = 1'b0;
        // doneCom ends the command, the watchdog catches a hang
        while (!doneCom) begin
            @(posedge clk);
            #drive;
        end
    endtask

    task automatic readBack(input memAddrT first, input memAddrT lastA);
        for (int a = int'(first); a <= int'(lastA); a++) begin
            @(posedge clk);
            #drive;
            rdAddr  = memAddrT'(a);
            rdCheck = 1'b1;
        end
        @(posedge clk);
        #drive;
        rdCheck = 1'b0;
        repeat (2) @(posedge clk);
        #drive;
    endtask

    initial begin : stimulus
        rstN        = 1'b0;
        start       = 1'b0;
        rdWr        = 1'b0;
        slaveId     = '0;
        address     = '0;
        lastAddress = '0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        rdAddr      = '0;
        rdCheck     = 1'b0;
        cmdAddr     = '0;
        loadSeed    = 32'd23;
        tbErrors    = 0;
        repeat (4) @(posedge clk);
        #drive;
        rstN = 1'b1;
        loadRange(12'd0, 12'd63);
        // rdWr high is a write
        runCommand(1'b1, 2'd1, 12'd5, 12'd5);
        runCommand(1'b1, 2'd2, 12'd10, 12'd17);
        runCommand(1'b0, 2'd3, 12'd32, 12'd41);
        readBack(12'd0, 12'd63);
        if (doneCount != numCmds) begin
            tbErrors++;
            $display("saw %0d doneCom pulses for %0d commands", doneCount, numCmds);
        end
        $display("error counts: %0d mismatches, %0d other checks, %0d testbench checks",
                 mismatchCount, otherCount, tbErrors);
        if (mismatchCount + otherCount + tbErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeLimit);
        $display("run timed out at %0t before the command sequence finished", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/busMasterPkg.sv
src/localMemory.sv
src/arbiterLink.sv
src/controlSerializer.sv
src/dataLink.sv
src/masterControl.sv
src/busMaster.sv
tb/tbClock.sv
tb/busMasterChecker.sv
tb/busMasterTb.sv

//--- Makefile
# Verilator build and run for the bus master testbench

VERILATOR ?= verilator
TOP       ?= busMasterTb
RTL_TOP   ?= busMaster
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
